// ==== rv_exec_core.f ====
common/rv_pkg.sv
common/wb_if.sv
verilog/rv_control.sv
verilog/rv_alu.sv
lsu/rv_lsu.sv
regs/rv_regs.sv
verilog/rv_exec_core.sv
verif/rv_exec_core_sva.sv
verif/tb_rv_exec_core.sv

// ==== Makefile ====
# Verilator build and run for the RV64I execute slice testbench.

VERILATOR ?= verilator
TOP       ?= tb_rv_exec_core
FILELIST  ?= rv_exec_core.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED

BIN := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/tb_rv_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_core;

    localparam int MEM_WORDS = 64;

    logic             clk;
    logic             rst;
    logic             instr_valid;
    rv_pkg::instr_t   instr;
    rv_pkg::reg_idx_t dbg_addr;
    rv_pkg::xlen_t    pc;
    logic             halted;
    rv_pkg::xlen_t    dbg_data;

    rv_pkg::xlen_t gold_x [32];
    rv_pkg::xlen_t gold_mem [MEM_WORDS];
    rv_pkg::xlen_t gold_pc;
    int            errors;
    int            checks;
    int            tests;
    int            failed;

    rv_exec_core #(
        .MEM_WORDS (MEM_WORDS)
    ) rv_exec_core_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dbg_addr    (dbg_addr),
        .pc          (pc),
        .halted      (halted),
        .dbg_data    (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // PC follows the model at every falling edge.
    pc_tracks_model: assert property (@(negedge clk) disable iff (!rst) pc == gold_pc)
        else begin
            errors++;
            $display("error: time %0t pc got %h expected %h", $time, pc, gold_pc);
        end

    // ***********************************************************
    // Encoders and model helpers
    // ***********************************************************

    function automatic rv_pkg::instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
        input rv_pkg::reg_idx_t rd, input rv_pkg::reg_idx_t rs1, input rv_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP};
    endfunction

    function automatic rv_pkg::instr_t enc_i(input logic [6:0] op, input logic [2:0] f3,
        input rv_pkg::reg_idx_t rd, input rv_pkg::reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::instr_t enc_s(input rv_pkg::reg_idx_t rs1,
        input rv_pkg::reg_idx_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, rv_pkg::F3_D, imm[4:0], rv_pkg::STORE};
    endfunction

    function automatic rv_pkg::instr_t enc_u(input logic [6:0] op, input rv_pkg::reg_idx_t rd,
        input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::instr_t enc_j(input rv_pkg::reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::JAL};
    endfunction

    function automatic rv_pkg::xlen_t sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic rv_pkg::xlen_t upper(input logic [19:0] v);
        return {{32{v[19]}}, v, 12'h000};
    endfunction

    function automatic logic [5:0] mem_word(input rv_pkg::xlen_t addr);
        return 6'((addr >> 3) % MEM_WORDS); // Doubleword index, wrapped.
    endfunction

    task automatic write_gold(input rv_pkg::reg_idx_t rd, input rv_pkg::xlen_t val);
        if (rd != 5'd0) begin
            gold_x[rd] = val;
        end
    endtask

    task automatic mismatch(input string name, input rv_pkg::xlen_t got,
        input rv_pkg::xlen_t exp);
        errors++;
        $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic issue(input rv_pkg::instr_t w);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    // One register through the debug port, plus pc and halted.
    task automatic check_reg(input rv_pkg::reg_idx_t idx, input logic exp_halted);
        @(posedge clk);
        dbg_addr <= idx;
        @(negedge clk);
        checks++;
        assert (dbg_data === gold_x[idx])
            else mismatch($sformatf("dbg_data[x%0d]", idx), dbg_data, gold_x[idx]);
        assert (pc === gold_pc) else mismatch("pc", pc, gold_pc);
        assert (halted === exp_halted) else mismatch("halted", 64'(halted), 64'(exp_halted));
    endtask

    task automatic sweep_regs(input logic exp_halted);
        for (int i = 0; i < 32; i++) begin
            check_reg(rv_pkg::reg_idx_t'(i), exp_halted);
        end
    endtask

    task automatic run_alu(input int kind, input rv_pkg::reg_idx_t rd,
        input rv_pkg::reg_idx_t rs1, input rv_pkg::reg_idx_t rs2, input logic [11:0] imm);
        rv_pkg::instr_t w;
        rv_pkg::xlen_t  r;
        case (kind)
            0: begin
                w = enc_i(rv_pkg::OP_IMM, rv_pkg::F3_ADD, rd, rs1, imm);
                r = gold_x[rs1] + sext12(imm);
            end
            1: begin
                w = enc_r(rv_pkg::F7_BASE, rv_pkg::F3_ADD, rd, rs1, rs2);
                r = gold_x[rs1] + gold_x[rs2];
            end
            2: begin
                w = enc_r(rv_pkg::F7_SUB, rv_pkg::F3_ADD, rd, rs1, rs2);
                r = gold_x[rs1] - gold_x[rs2];
            end
            3: begin
                w = enc_r(rv_pkg::F7_BASE, rv_pkg::F3_AND, rd, rs1, rs2);
                r = gold_x[rs1] & gold_x[rs2];
            end
            4: begin
                w = enc_r(rv_pkg::F7_BASE, rv_pkg::F3_OR, rd, rs1, rs2);
                r = gold_x[rs1] | gold_x[rs2];
            end
            default: begin
                w = enc_r(rv_pkg::F7_BASE, rv_pkg::F3_XOR, rd, rs1, rs2);
                r = gold_x[rs1] ^ gold_x[rs2];
            end
        endcase
        issue(w);
        write_gold(rd, r);
        gold_pc = gold_pc + 64'd4;
        check_reg(rd, 1'b0);
    endtask

    task automatic run_mem(input logic is_store, input rv_pkg::reg_idx_t reg_d,
        input rv_pkg::reg_idx_t base, input logic [11:0] off);
        logic [5:0] idx;
        idx = mem_word(gold_x[base] + sext12(off));
        if (is_store) begin
            issue(enc_s(base, reg_d, off));
            gold_mem[idx] = gold_x[reg_d];
        end else begin
            issue(enc_i(rv_pkg::LOAD, rv_pkg::F3_D, reg_d, base, off));
            write_gold(reg_d, gold_mem[idx]);
        end
        gold_pc = gold_pc + 64'd4;
        check_reg(reg_d, 1'b0);
    endtask

    // ***********************************************************
    // Tests
    // ***********************************************************

    task automatic test_upper_jump();
        rv_pkg::xlen_t old_pc;
        issue(enc_u(rv_pkg::LUI, 5'd7, 20'habcde));
        write_gold(5'd7, upper(20'habcde));
        gold_pc = gold_pc + 64'd4;
        check_reg(5'd7, 1'b0);
        old_pc = gold_pc;
        issue(enc_u(rv_pkg::AUIPC, 5'd8, 20'h80012));
        write_gold(5'd8, old_pc + upper(20'h80012));
        gold_pc = old_pc + 64'd4;
        check_reg(5'd8, 1'b0);
        old_pc = gold_pc;
        issue(enc_j(5'd9, 21'd16));
        write_gold(5'd9, old_pc + 64'd4);
        gold_pc = old_pc + 64'd16;
        check_reg(5'd9, 1'b0);
        old_pc = gold_pc;
        issue(enc_j(5'd10, 21'h1ffff8)); // Backward by 8.
        write_gold(5'd10, old_pc + 64'd4);
        gold_pc = old_pc - 64'd8;
        check_reg(5'd10, 1'b0);
        repeat (6) begin
            @(posedge clk);
            instr <= $urandom; // Ignored while instr_valid is low.
        end
        for (int i = 7; i <= 10; i++) begin
            check_reg(rv_pkg::reg_idx_t'(i), 1'b0);
        end
    endtask

    task automatic test_ebreak();
        int n;
        issue(enc_i(rv_pkg::SYSTEM, 3'b000, 5'd0, 5'd0, 12'h001));
        gold_pc = gold_pc + 64'd4;
        n = 0;
        while (halted !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (halted !== 1'b1) begin
            errors++;
            $display("timeout: halted did not rise after EBREAK");
        end
        issue(enc_i(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 5'd1, 5'd0, 12'h063));
        issue(enc_j(5'd2, 21'd32));
        sweep_regs(1'b1);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int mark;
        void'($urandom(96880));
        errors      = 0;
        checks      = 0;
        tests       = 0;
        failed      = 0;
        gold_x      = '{default: '0};
        gold_mem    = '{default: '0};
        gold_pc     = '0;
        rst         = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        dbg_addr    = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        mark = errors;
        sweep_regs(1'b0);
        finish_test("reset", mark);

        mark = errors;
        for (int i = 1; i <= 8; i++) begin
            run_alu(0, rv_pkg::reg_idx_t'(i), 5'd0, 5'd0, 12'($urandom));
        end
        for (int i = 0; i < 24; i++) begin
            run_alu(int'($urandom_range(5, 0)), rv_pkg::reg_idx_t'($urandom_range(15, 1)),
                rv_pkg::reg_idx_t'($urandom_range(15, 0)),
                rv_pkg::reg_idx_t'($urandom_range(15, 0)), 12'($urandom));
        end
        finish_test("alu_random", mark);

        mark = errors;
        run_alu(0, 5'd5, 5'd0, 5'd0, 12'h123);
        run_alu(0, 5'd0, 5'd5, 5'd0, 12'h07b);
        run_alu(1, 5'd0, 5'd5, 5'd5, 12'h000);
        run_alu(1, 5'd6, 5'd0, 5'd0, 12'h000);
        check_reg(5'd0, 1'b0);
        finish_test("x0", mark);

        mark = errors;
        test_upper_jump();
        finish_test("upper_jump", mark);

        mark = errors;
        run_alu(0, 5'd11, 5'd0, 5'd0, 12'h040);
        run_alu(0, 5'd12, 5'd0, 5'd0, 12'hffb);
        run_mem(1'b1, 5'd12, 5'd11, 12'h008);
        run_mem(1'b0, 5'd13, 5'd11, 12'h008);
        run_mem(1'b0, 5'd14, 5'd0, 12'h248); // Wraps onto the same doubleword.
        run_mem(1'b1, 5'd7, 5'd11, 12'hff8);
        run_mem(1'b0, 5'd15, 5'd0, 12'h038);
        run_mem(1'b0, 5'd16, 5'd0, 12'h100);
        finish_test("store_load", mark);

        mark = errors;
        test_ebreak();
        finish_test("ebreak", mark);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/rv_exec_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core_sva (
    input wire                    clk,
    input wire                    rst,
    input wire                    instr_valid,
    input wire                    halted,
    input wire rv_pkg::xlen_t     pc,
    input wire rv_pkg::reg_idx_t  rs1,
    input wire rv_pkg::xlen_t     rs1_data,
    input wire rv_pkg::reg_idx_t  dbg_addr,
    input wire rv_pkg::xlen_t     dbg_data
);

    // ***********************************************************
    // Register file
    // ***********************************************************

    x0_operand_zero: assert property (@(posedge clk) (rs1 == 5'd0) |-> (rs1_data == '0))
        else $error("x0 read as operand is not zero");

    x0_debug_zero: assert property (@(posedge clk) (dbg_addr == 5'd0) |-> (dbg_data == '0))
        else $error("x0 read on debug port is not zero");

    // ***********************************************************
    // Control state
    // ***********************************************************

    halt_sticky: assert property (@(posedge clk) $fell(halted) |-> !$past(rst))
        else $error("halted fell without reset");

    // No accepted instruction, no PC change.
    pc_hold: assert property (@(posedge clk) disable iff (!rst)
        !(instr_valid && !halted) |=> $stable(pc))
        else $error("pc changed without an accepted instruction");

    reset_state: assert property (@(posedge clk) !rst |=> (pc == '0) && !halted)
        else $error("pc or halted not cleared by reset");

endmodule

bind rv_exec_core rv_exec_core_sva rv_exec_core_sva_i (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .halted      (halted),
    .pc          (pc),
    .rs1         (rs1),
    .rs1_data    (rs1_data),
    .dbg_addr    (dbg_addr),
    .dbg_data    (dbg_data)
);

`default_nettype wire

// ==== verilog/rv_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core #(
    parameter int MEM_WORDS = rv_pkg::MEM_WORDS
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    instr_valid,
    input  wire  rv_pkg::instr_t   instr,
    input  wire  rv_pkg::reg_idx_t dbg_addr,
    output rv_pkg::xlen_t          pc,
    output logic                   halted,
    output rv_pkg::xlen_t          dbg_data
);

    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::xlen_t    rs1_data;
    rv_pkg::xlen_t    rs2_data;
    rv_pkg::alu_op_t  alu_op;
    logic             src_a_pc;
    logic             src_b_imm;
    logic             mem_we;

    wb_if wb_bus ();

    // ***********************************************************
    // Control and execute units
    // ***********************************************************

    rv_control rv_control_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .halted      (halted),
        .rs1         (rs1),
        .rs2         (rs2),
        .alu_op      (alu_op),
        .src_a_pc    (src_a_pc),
        .src_b_imm   (src_b_imm),
        .mem_we      (mem_we),
        .wb          (wb_bus.ctrl)
    );

    rv_alu rv_alu_i (
        .src_a_pc  (src_a_pc),
        .src_b_imm (src_b_imm),
        .alu_op    (alu_op),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb        (wb_bus.alu)
    );

    rv_lsu #(
        .MEM_WORDS (MEM_WORDS)
    ) rv_lsu_i (
        .clk      (clk),
        .rst      (rst),
        .mem_we   (mem_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb_bus.lsu)
    );

    // Register file closes the loop.
    rv_regs rv_regs_i (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .dbg_addr (dbg_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data),
        .wb       (wb_bus.regs)
    );

endmodule

`default_nettype wire

// ==== regs/rv_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regs (
    input  wire                    clk,
    input  wire                    rst,
    input  wire  rv_pkg::reg_idx_t rs1,
    input  wire  rv_pkg::reg_idx_t rs2,
    input  wire  rv_pkg::reg_idx_t dbg_addr,
    output rv_pkg::xlen_t          rs1_data,
    output rv_pkg::xlen_t          rs2_data,
    output rv_pkg::xlen_t          dbg_data,
    wb_if.regs                     wb
);

    // x0 has no storage.
    rv_pkg::xlen_t x [1:31];
    rv_pkg::xlen_t wr_data;
    logic          wr_en;

    function automatic rv_pkg::xlen_t read_reg(input rv_pkg::reg_idx_t idx);
        rv_pkg::xlen_t val;
        val = '0;
        if (idx != 5'd0) begin
            val = x[idx];
        end
        return val;
    endfunction

    // ***********************************************************
    // Read ports
    // ***********************************************************

    assign rs1_data = read_reg(rs1);
    assign rs2_data = read_reg(rs2);
    assign dbg_data = read_reg(dbg_addr);

    // ***********************************************************
    // Write-back
    // ***********************************************************

    always_comb begin
        case (wb.sel)
            rv_pkg::WB_ALU:  wr_data = wb.alu_result;
            rv_pkg::WB_SNPC: wr_data = wb.snpc;
            rv_pkg::WB_IMM:  wr_data = wb.imm;
            rv_pkg::WB_MEM:  wr_data = wb.mem_data;
            default:         wr_data = '0;
        endcase
    end

    // Writes to x0 are dropped.
    assign wr_en = (wb.sel != rv_pkg::WB_NONE) && (wb.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                x[i] <= '0;
            end
        end else if (wr_en) begin
            x[wb.rd] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== lsu/rv_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_lsu #(
    parameter int MEM_WORDS = rv_pkg::MEM_WORDS
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   mem_we,
    input  wire  rv_pkg::xlen_t   rs1_data,
    input  wire  rv_pkg::xlen_t   rs2_data,
    wb_if.lsu                     wb
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    rv_pkg::xlen_t    mem [MEM_WORDS];
    rv_pkg::xlen_t    addr;
    logic [IDX_W-1:0] word_idx;

    // ***********************************************************
    // Address
    // ***********************************************************

    assign addr = rs1_data + wb.imm;

    // Doubleword index wraps over the memory depth.
    assign word_idx = IDX_W'((addr >> 3) % MEM_WORDS);

    // ***********************************************************
    // Data memory
    // ***********************************************************

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_we) begin
            mem[word_idx] <= rs2_data;
        end
    end

    assign wb.mem_data = mem[word_idx]; // Asynchronous read.

endmodule

`default_nettype wire

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire                    src_a_pc,
    input  wire                    src_b_imm,
    input  wire  rv_pkg::alu_op_t  alu_op,
    input  wire  rv_pkg::xlen_t    pc,
    input  wire  rv_pkg::xlen_t    rs1_data,
    input  wire  rv_pkg::xlen_t    rs2_data,
    wb_if.alu                      wb
);

    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    rv_pkg::xlen_t result;

    // ***********************************************************
    // Operand select
    // ***********************************************************

    assign op_a = src_a_pc  ? pc     : rs1_data; // PC for AUIPC.
    assign op_b = src_b_imm ? wb.imm : rs2_data;

    // ***********************************************************
    // Operation
    // ***********************************************************

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD: begin
                result = op_a + op_b;
            end
            rv_pkg::ALU_SUB: begin
                result = op_a - op_b;
            end
            rv_pkg::ALU_AND: begin
                result = op_a & op_b;
            end
            rv_pkg::ALU_OR: begin
                result = op_a | op_b;
            end
            rv_pkg::ALU_XOR: begin
                result = op_a ^ op_b;
            end
            rv_pkg::ALU_PASS_B: begin
                result = op_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign wb.alu_result = result;

endmodule

`default_nettype wire

// ==== verilog/rv_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_control (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    instr_valid,
    input  wire  rv_pkg::instr_t   instr,
    output rv_pkg::xlen_t          pc,
    output logic                   halted,
    output rv_pkg::reg_idx_t       rs1,
    output rv_pkg::reg_idx_t       rs2,
    output rv_pkg::alu_op_t        alu_op,
    output logic                   src_a_pc,
    output logic                   src_b_imm,
    output logic                   mem_we,
    wb_if.ctrl                     wb
);

    typedef enum logic {RUN, HALT} state_t;

    state_t          state;
    logic            accept;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    rv_pkg::xlen_t   imm_i, imm_s, imm_u, imm_j;
    rv_pkg::xlen_t   imm;
    rv_pkg::xlen_t   snpc;
    rv_pkg::wb_sel_t sel_d;
    logic            store;
    logic            is_jal;
    logic            is_ebreak;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // ***********************************************************
    // Decode
    // ***********************************************************

    always_comb begin
        sel_d     = rv_pkg::WB_NONE;
        alu_op    = rv_pkg::ALU_ADD;
        src_a_pc  = 1'b0;
        src_b_imm = 1'b0;
        imm       = imm_i;
        store     = 1'b0;
        is_jal    = 1'b0;
        is_ebreak = 1'b0;
        case (opcode)
            rv_pkg::OP_IMM: begin
                if (funct3 == rv_pkg::F3_ADD) begin
                    sel_d     = rv_pkg::WB_ALU;
                    src_b_imm = 1'b1;
                end
            end
            rv_pkg::OP: begin
                if (funct7 == rv_pkg::F7_BASE) begin
                    sel_d = rv_pkg::WB_ALU;
                    case (funct3)
                        rv_pkg::F3_ADD: alu_op = rv_pkg::ALU_ADD;
                        rv_pkg::F3_XOR: alu_op = rv_pkg::ALU_XOR;
                        rv_pkg::F3_OR:  alu_op = rv_pkg::ALU_OR;
                        rv_pkg::F3_AND: alu_op = rv_pkg::ALU_AND;
                        default:        sel_d  = rv_pkg::WB_NONE;
                    endcase
                end else if (funct7 == rv_pkg::F7_SUB && funct3 == rv_pkg::F3_ADD) begin
                    sel_d  = rv_pkg::WB_ALU;
                    alu_op = rv_pkg::ALU_SUB;
                end
            end
            rv_pkg::LUI: begin
                sel_d = rv_pkg::WB_IMM;
                imm   = imm_u;
            end
            rv_pkg::AUIPC: begin
                sel_d     = rv_pkg::WB_ALU;
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                imm       = imm_u;
            end
            rv_pkg::JAL: begin
                sel_d  = rv_pkg::WB_SNPC; // Link register gets PC plus 4.
                imm    = imm_j;
                is_jal = 1'b1;
            end
            rv_pkg::LOAD: begin
                if (funct3 == rv_pkg::F3_D) sel_d = rv_pkg::WB_MEM;
            end
            rv_pkg::STORE: begin
                if (funct3 == rv_pkg::F3_D) store = 1'b1;
                imm = imm_s;
            end
            rv_pkg::SYSTEM: begin
                if (instr == rv_pkg::INSTR_EBREAK) is_ebreak = 1'b1;
            end
            default: ;
        endcase
    end

    // Every side effect waits for an accepted instruction.
    assign accept  = instr_valid && (state == RUN);
    assign mem_we  = accept && store;
    assign snpc    = pc + 64'd4;
    assign halted  = (state == HALT);

    assign wb.sel  = accept ? sel_d : rv_pkg::WB_NONE;
    assign wb.rd   = instr[11:7];
    assign wb.imm  = imm;
    assign wb.snpc = snpc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= '0;
        end else if (accept) begin
            pc <= is_jal ? pc + imm : snpc;
        end
    end

    // Halt is sticky until reset.
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= RUN;
        end else if (accept && is_ebreak) begin
            state <= HALT;
        end
    end

endmodule

`default_nettype wire

// ==== common/wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Write-back candidates and their control, gathered for the register file.
interface wb_if;

    rv_pkg::wb_sel_t  sel;        // Write-back source.
    rv_pkg::reg_idx_t rd;         // Destination register.
    rv_pkg::xlen_t    imm;        // Decoded immediate.
    rv_pkg::xlen_t    snpc;       // PC plus 4.
    rv_pkg::xlen_t    alu_result;
    rv_pkg::xlen_t    mem_data;   // Load data.

    modport ctrl (
        output sel, rd, imm, snpc
    );

    modport alu (
        input  imm,
        output alu_result
    );

    modport lsu (
        input  imm,
        output mem_data
    );

    modport regs (
        input sel, rd, imm, snpc, alu_result, mem_data
    );

endinterface

`default_nettype wire

// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // ***********************************************************
    // Word and index types
    // ***********************************************************

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;    // Register or data word.
    typedef logic [31:0]     instr_t;   // Instruction word.
    typedef logic [4:0]      reg_idx_t; // Register index.

    // Data memory depth in doublewords.
    localparam int MEM_WORDS = 64;

    // ***********************************************************
    // Encodings
    // ***********************************************************

    // Major opcodes.
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] SYSTEM = 7'b1110011;

    // Funct3 codes.
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_D   = 3'b011; // Doubleword load and store.

    // Funct7 codes.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // EBREAK has a single fixed encoding.
    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

    // ***********************************************************
    // Control enums
    // ***********************************************************

    typedef enum logic [2:0] {
        WB_NONE = 3'd0, // No register write.
        WB_ALU  = 3'd1,
        WB_SNPC = 3'd2,
        WB_IMM  = 3'd3,
        WB_MEM  = 3'd4
    } wb_sel_t;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_t;

endpackage

`default_nettype wire
